// File: src/pmp_pkg.sv
// Shared types and constants of the PMP unit

package pmp_pkg;

   // --------------------------------------------------
   // Types
   // --------------------------------------------------

   // CSR address and data as seen on the core's CSR port
   typedef logic [11:0] csr_addr_t;
   typedef logic [31:0] csr_data_t;

   // One entry configuration byte: L, 0, 0, A[1:0], X, W, R
   typedef logic [7:0] pmp_cfg_t;

   // Word address of a region bound, bits 31:30 are always zero
   typedef logic [31:0] pmp_addr_t;

   // Byte address of an access under check
   typedef logic [31:0] phys_addr_t;

   // One-hot access kind, bit order matches R, W, X in the cfg byte
   typedef logic [2:0] access_t;

   // --------------------------------------------------
   // CSR map
   // --------------------------------------------------

   // Each base spans 16 CSRs, the low nibble is the index
   localparam csr_addr_t CSR_PMPCFG_BASE    = 12'h3a0;
   localparam csr_addr_t CSR_PMPADDR0_BASE  = 12'h3b0;
   localparam csr_addr_t CSR_PMPADDR16_BASE = 12'h3c0;
   localparam csr_addr_t CSR_PMPADDR32_BASE = 12'h3d0;
   localparam csr_addr_t CSR_PMPADDR48_BASE = 12'h3e0;

   // Bit positions inside pmp_cfg_t
   localparam int CFG_R    = 0;
   localparam int CFG_W    = 1;
   localparam int CFG_X    = 2;
   localparam int CFG_A_LO = 3;  // A field spans bits 4:3
   localparam int CFG_L    = 7;

   // Address-match modes held in the A field
   localparam logic [1:0] MODE_OFF   = 2'd0;
   localparam logic [1:0] MODE_TOR   = 2'd1;
   localparam logic [1:0] MODE_NA4   = 2'd2;
   localparam logic [1:0] MODE_NAPOT = 2'd3;

   // Reserved cfg bits 6:5 are hardwired to zero
   localparam pmp_cfg_t CFG_WARL_MASK = 8'h9f;

endpackage

// File: src/pmp_csr_regs.sv
`timescale 1ns/100ps

// pmpcfg and pmpaddr CSR storage with WARL and lock handling
module pmp_csr_regs #(
   parameter int pmp_entries = 16
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                csr_wen,
   input  pmp_pkg::csr_addr_t  csr_waddr,
   input  pmp_pkg::csr_data_t  csr_wdata,
   input  pmp_pkg::csr_addr_t  csr_raddr,
   output pmp_pkg::csr_data_t  csr_rdata,
   output logic                csr_rhit,
   output pmp_pkg::pmp_cfg_t   pmp_cfg [pmp_entries],
   output pmp_pkg::pmp_addr_t  pmp_addr [pmp_entries]
);

   // Decoded write and read addresses
   logic       wr_cfg_sel;
   logic       wr_addr_sel;
   logic [5:0] wr_idx;
   logic       rd_cfg_sel;
   logic       rd_addr_sel;
   logic [5:0] rd_idx;

   // Zero-padded views for the read mux, 64 is the architectural maximum
   pmp_pkg::pmp_cfg_t  cfg_ext  [64];
   pmp_pkg::pmp_addr_t addr_ext [64];

   // --------------------------------------------------
   // Address decode
   // --------------------------------------------------

   // Returns {cfg hit, addr hit, quarter, low nibble}
   // For pmpcfg the low nibble is the group of four entries
   function automatic logic [7:0] csr_decode(input pmp_pkg::csr_addr_t a);
      logic       cfg_hit;
      logic       addr_hit;
      logic [1:0] quarter;
      cfg_hit  = (a[11:4] == pmp_pkg::CSR_PMPCFG_BASE[11:4]);
      addr_hit = 1'b1;
      quarter  = 2'd0;
      case (a[11:4])
         pmp_pkg::CSR_PMPADDR0_BASE[11:4]:  quarter = 2'd0;
         pmp_pkg::CSR_PMPADDR16_BASE[11:4]: quarter = 2'd1;
         pmp_pkg::CSR_PMPADDR32_BASE[11:4]: quarter = 2'd2;
         pmp_pkg::CSR_PMPADDR48_BASE[11:4]: quarter = 2'd3;
         default:                           addr_hit = 1'b0;
      endcase
      return {cfg_hit, addr_hit, quarter, a[3:0]};
   endfunction

   assign {wr_cfg_sel, wr_addr_sel, wr_idx} = csr_decode(csr_waddr);
   assign {rd_cfg_sel, rd_addr_sel, rd_idx} = csr_decode(csr_raddr);

   // --------------------------------------------------
   // Per-entry registers
   // --------------------------------------------------

   for (genvar i = 0; i < pmp_entries; i++) begin : g_entry
      logic               [7:0] raw_byte;
      pmp_pkg::pmp_cfg_t  cfg_wdata;
      pmp_pkg::pmp_cfg_t  cfg_q;
      pmp_pkg::pmp_addr_t addr_q;
      logic               cfg_we;
      logic               addr_we;
      logic               next_tor_lock;
      logic               addr_lock;

      // Byte lane of this entry within its pmpcfg group
      assign raw_byte = csr_wdata[8 * (i % 4) +: 8];

      // Drop reserved bits, and W=1 with R=0 is not a legal combination
      always_comb begin
         cfg_wdata = raw_byte & pmp_pkg::CFG_WARL_MASK;
         if (!raw_byte[pmp_pkg::CFG_R]) begin
            cfg_wdata[pmp_pkg::CFG_W] = 1'b0;
         end
      end

      // A locked TOR entry above also uses this address as its base
      if (i + 1 < pmp_entries) begin : g_next
         assign next_tor_lock = pmp_cfg[i + 1][pmp_pkg::CFG_L]
            & (pmp_cfg[i + 1][pmp_pkg::CFG_A_LO +: 2] == pmp_pkg::MODE_TOR);
      end else begin : g_last
         assign next_tor_lock = 1'b0;
      end

      assign addr_lock = cfg_q[pmp_pkg::CFG_L] | next_tor_lock;

      assign cfg_we  = csr_wen & wr_cfg_sel & (wr_idx[3:0] == 4'(i / 4))
                       & ~cfg_q[pmp_pkg::CFG_L];
      assign addr_we = csr_wen & wr_addr_sel & (wr_idx == 6'(i)) & ~addr_lock;

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            cfg_q <= '0;
         end else if (cfg_we) begin
            cfg_q <= cfg_wdata;
         end
      end

      // Only 32-bit physical space, upper two bits stay zero
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            addr_q <= '0;
         end else if (addr_we) begin
            addr_q <= {2'b00, csr_wdata[29:0]};
         end
      end

      assign pmp_cfg[i]  = cfg_q;
      assign pmp_addr[i] = addr_q;
   end

   // --------------------------------------------------
   // Read mux
   // --------------------------------------------------

   // Unimplemented entries read as zero
   for (genvar e = 0; e < 64; e++) begin : g_ext
      if (e < pmp_entries) begin : g_impl
         assign cfg_ext[e]  = pmp_cfg[e];
         assign addr_ext[e] = pmp_addr[e];
      end else begin : g_none
         assign cfg_ext[e]  = '0;
         assign addr_ext[e] = '0;
      end
   end

   always_comb begin
      csr_rdata = '0;
      if (rd_cfg_sel) begin
         // Four cfg bytes packed, lowest entry in the low byte
         for (int j = 0; j < 4; j++) begin
            csr_rdata[8 * j +: 8] = cfg_ext[{rd_idx[3:0], 2'(j)}];
         end
      end else if (rd_addr_sel) begin
         csr_rdata = addr_ext[rd_idx];
      end
   end

   assign csr_rhit = rd_cfg_sel | rd_addr_sel;

endmodule

// File: src/pmp_region_match.sv
`timescale 1ns/100ps

// Decides whether one access address falls in one PMP region
module pmp_region_match (
   input  pmp_pkg::phys_addr_t chk_addr,
   input  pmp_pkg::pmp_cfg_t   cfg,
   input  pmp_pkg::pmp_addr_t  addr,
   input  pmp_pkg::pmp_addr_t  prev_addr,
   output logic                match
);

   // --------------------------------------------------
   // Operands
   // --------------------------------------------------

   // Access address in the same word units as pmpaddr
   pmp_pkg::pmp_addr_t word;

   // Low bits ignored by a NAPOT compare
   pmp_pkg::pmp_addr_t napot_mask;

   // Per-mode compare results
   logic       tor_hit;
   logic       na4_hit;
   logic       napot_hit;
   logic [1:0] mode;

   assign word = {2'b00, chk_addr[31:2]};
   assign mode = cfg[pmp_pkg::CFG_A_LO +: 2];

   // Ones from bit 0 through the first zero of addr
   // k trailing ones give k+1 ignored word bits, 2^(k+3) bytes
   assign napot_mask = addr ^ (addr + 32'd1);

   // --------------------------------------------------
   // Compares
   // --------------------------------------------------

   // Top of range, previous entry's address is the inclusive base
   assign tor_hit = (word >= prev_addr) & (word < addr);

   // Single naturally aligned word
   assign na4_hit = (word == addr);

   // Compare only the bits above the region size
   assign napot_hit = ((word & ~napot_mask) == (addr & ~napot_mask));

   always_comb begin
      case (mode)
         pmp_pkg::MODE_TOR:   match = tor_hit;
         pmp_pkg::MODE_NA4:   match = na4_hit;
         pmp_pkg::MODE_NAPOT: match = napot_hit;
         default:             match = 1'b0;  // OFF
      endcase
   end

endmodule

// File: src/pmp_priority_resolve.sv
`timescale 1ns/100ps

// Lowest matching entry wins, then privilege and permission rules apply
module pmp_priority_resolve #(
   parameter int pmp_entries = 16
) (
   input  logic [pmp_entries-1:0] match,
   input  pmp_pkg::pmp_cfg_t      pmp_cfg [pmp_entries],
   input  pmp_pkg::access_t       chk_access,
   input  logic                   chk_user,
   output logic                   chk_fault
);

   // Winning entry
   logic              hit;
   pmp_pkg::pmp_cfg_t hit_cfg;

   // R, W, X of the winner in access bit order
   pmp_pkg::access_t  perm;
   logic              denied;

   // --------------------------------------------------
   // Priority select
   // --------------------------------------------------

   // Walk down so the lowest index is the last one kept
   always_comb begin
      hit     = 1'b0;
      hit_cfg = '0;
      for (int i = pmp_entries - 1; i >= 0; i--) begin
         if (match[i]) begin
            hit     = 1'b1;
            hit_cfg = pmp_cfg[i];
         end
      end
   end

   // --------------------------------------------------
   // Permission check
   // --------------------------------------------------

   assign perm = hit_cfg[pmp_pkg::CFG_X:pmp_pkg::CFG_R];

   // Any requested kind without its permission bit
   assign denied = |(chk_access & ~perm);

   // No match: user faults, machine passes
   // Match: machine mode is only held to locked entries
   assign chk_fault = hit ? (denied & (chk_user | hit_cfg[pmp_pkg::CFG_L]))
                          : chk_user;

endmodule

// File: src/pmp_unit.sv
`timescale 1ns/100ps

// PMP top level, CSR file plus per-entry matchers and the resolver
module pmp_unit #(
   parameter int pmp_entries = 16
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                csr_wen,
   input  pmp_pkg::csr_addr_t  csr_waddr,
   input  pmp_pkg::csr_data_t  csr_wdata,
   input  pmp_pkg::csr_addr_t  csr_raddr,
   output pmp_pkg::csr_data_t  csr_rdata,
   output logic                csr_rhit,
   input  pmp_pkg::phys_addr_t chk_addr,
   input  pmp_pkg::access_t    chk_access,
   input  logic                chk_user,
   output logic                chk_fault
);

   pmp_pkg::pmp_cfg_t      pmp_cfg   [pmp_entries];
   pmp_pkg::pmp_addr_t     pmp_addr  [pmp_entries];
   pmp_pkg::pmp_addr_t     prev_addr [pmp_entries];
   logic [pmp_entries-1:0] match;

   // --------------------------------------------------
   // CSR file
   // --------------------------------------------------

   pmp_csr_regs #(
      .pmp_entries (pmp_entries)
   ) u_csr_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .csr_wen   (csr_wen),
      .csr_waddr (csr_waddr),
      .csr_wdata (csr_wdata),
      .csr_raddr (csr_raddr),
      .csr_rdata (csr_rdata),
      .csr_rhit  (csr_rhit),
      .pmp_cfg   (pmp_cfg),
      .pmp_addr  (pmp_addr)
   );

   // --------------------------------------------------
   // Region matchers
   // --------------------------------------------------

   for (genvar i = 0; i < pmp_entries; i++) begin : g_match
      // TOR base of entry 0 is address zero
      if (i == 0) begin : g_first
         assign prev_addr[i] = '0;
      end else begin : g_rest
         assign prev_addr[i] = pmp_addr[i - 1];
      end

      pmp_region_match u_match (
         .chk_addr  (chk_addr),
         .cfg       (pmp_cfg[i]),
         .addr      (pmp_addr[i]),
         .prev_addr (prev_addr[i]),
         .match     (match[i])
      );
   end

   // --------------------------------------------------
   // Resolver
   // --------------------------------------------------

   pmp_priority_resolve #(
      .pmp_entries (pmp_entries)
   ) u_resolve (
      .match      (match),
      .pmp_cfg    (pmp_cfg),
      .chk_access (chk_access),
      .chk_user   (chk_user),
      .chk_fault  (chk_fault)
   );

endmodule

// File: include/pmp_tb_checks.svh
`ifndef PMP_TB_CHECKS_SVH
`define PMP_TB_CHECKS_SVH

// Running tallies over all tests
int error_count = 0;
int pass_count  = 0;

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------

// CSR read data
task automatic check_csr(input string name, input pmp_pkg::csr_data_t expected,
                         input pmp_pkg::csr_data_t actual);
   if (actual !== expected) begin
      error_count++;
      $display("error at %0.1f ns: %s expected %08h actual %08h",
               $realtime, name, expected, actual);
   end else begin
      pass_count++;
   end
endtask

// CSR address decode flag
task automatic check_hit(input string name, input logic expected, input logic actual);
   if (actual !== expected) begin
      error_count++;
      $display("error at %0.1f ns: %s expected %b actual %b",
               $realtime, name, expected, actual);
   end else begin
      pass_count++;
   end
endtask

// Access check result
task automatic check_fault(input string name, input logic expected, input logic actual);
   if (actual !== expected) begin
      error_count++;
      $display("error at %0.1f ns: %s expected %b actual %b",
               $realtime, name, expected, actual);
   end else begin
      pass_count++;
   end
endtask

`endif

// File: tb/pmp_tb.sv
`timescale 1ns/100ps

module pmp_tb;

   `include "pmp_tb_checks.svh"

   localparam int      ENTRIES         = 16;
   localparam realtime CLK_PERIOD      = 4.0;
   localparam realtime DRIVE_DELAY     = 0.5;
   localparam int      WATCHDOG_CYCLES = 2000;

   logic                clk;
   logic                rst_n;
   logic                csr_wen;
   pmp_pkg::csr_addr_t  csr_waddr;
   pmp_pkg::csr_data_t  csr_wdata;
   pmp_pkg::csr_addr_t  csr_raddr;
   pmp_pkg::csr_data_t  csr_rdata;
   logic                csr_rhit;
   pmp_pkg::phys_addr_t chk_addr;
   pmp_pkg::access_t    chk_access;
   logic                chk_user;
   logic                chk_fault;

   // Reference copy of the CSR state
   pmp_pkg::pmp_cfg_t  model_cfg  [ENTRIES];
   pmp_pkg::pmp_addr_t model_addr [ENTRIES];

   integer seed = 32'h0822_83bd;

   pmp_unit #(
      .pmp_entries (ENTRIES)
   ) dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .csr_wen    (csr_wen),
      .csr_waddr  (csr_waddr),
      .csr_wdata  (csr_wdata),
      .csr_raddr  (csr_raddr),
      .csr_rdata  (csr_rdata),
      .csr_rhit   (csr_rhit),
      .chk_addr   (chk_addr),
      .chk_access (chk_access),
      .chk_user   (chk_user),
      .chk_fault  (chk_fault)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Ends a stuck run
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("TEST FAILED");
      $finish;
   end

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   // WARL masking and lock rules applied to one CSR write
   function automatic void ref_write(input pmp_pkg::csr_addr_t a,
                                     input pmp_pkg::csr_data_t d);
      pmp_pkg::pmp_cfg_t b;
      int                idx;
      logic              locked;
      if (a[11:4] == pmp_pkg::CSR_PMPCFG_BASE[11:4]) begin
         for (int j = 0; j < 4; j++) begin
            idx = 4 * int'(a[3:0]) + j;
            b = d[8 * j +: 8];
            b[6:5] = 2'b00;
            if (!b[pmp_pkg::CFG_R]) begin
               b[pmp_pkg::CFG_W] = 1'b0;
            end
            if (idx < ENTRIES) begin
               if (!model_cfg[idx][pmp_pkg::CFG_L]) begin
                  model_cfg[idx] = b;
               end
            end
         end
      end else if (a >= pmp_pkg::CSR_PMPADDR0_BASE
                   && a <= pmp_pkg::CSR_PMPADDR48_BASE + 12'hf) begin
         idx = int'(a - pmp_pkg::CSR_PMPADDR0_BASE);
         if (idx < ENTRIES) begin
            locked = model_cfg[idx][pmp_pkg::CFG_L];
            // Base of a locked TOR entry above
            if (idx + 1 < ENTRIES) begin
               if (model_cfg[idx + 1][pmp_pkg::CFG_L]
                   && model_cfg[idx + 1][pmp_pkg::CFG_A_LO +: 2] == pmp_pkg::MODE_TOR) begin
                  locked = 1'b1;
               end
            end
            if (!locked) begin
               model_addr[idx] = {2'b00, d[29:0]};
            end
         end
      end
   endfunction

   function automatic logic predict_hit(input pmp_pkg::csr_addr_t a);
      return (a[11:4] == pmp_pkg::CSR_PMPCFG_BASE[11:4])
             || (a >= pmp_pkg::CSR_PMPADDR0_BASE && a <= pmp_pkg::CSR_PMPADDR48_BASE + 12'hf);
   endfunction

   function automatic pmp_pkg::csr_data_t predict_read(input pmp_pkg::csr_addr_t a);
      pmp_pkg::csr_data_t d;
      int                 idx;
      d = '0;
      if (a[11:4] == pmp_pkg::CSR_PMPCFG_BASE[11:4]) begin
         for (int j = 0; j < 4; j++) begin
            idx = 4 * int'(a[3:0]) + j;
            if (idx < ENTRIES) begin
               d[8 * j +: 8] = model_cfg[idx];
            end
         end
      end else if (predict_hit(a)) begin
         idx = int'(a - pmp_pkg::CSR_PMPADDR0_BASE);
         if (idx < ENTRIES) begin
            d = model_addr[idx];
         end
      end
      return d;
   endfunction

   // First matching entry decides and no match leaves only machine mode
   function automatic logic predict_fault(input pmp_pkg::phys_addr_t pa,
                                          input pmp_pkg::access_t acc, input logic user);
      pmp_pkg::pmp_addr_t word;
      pmp_pkg::pmp_addr_t base;
      pmp_pkg::pmp_addr_t top;
      pmp_pkg::pmp_cfg_t  win;
      logic               hit;
      logic               found;
      logic               allowed;
      int                 k;
      word  = {2'b00, pa[31:2]};
      found = 1'b0;
      win   = '0;
      for (int i = 0; i < ENTRIES; i++) begin
         top  = model_addr[i];
         base = '0;
         if (i > 0) begin
            base = model_addr[i - 1];
         end
         // k trailing ones give a region of 2^(k+1) words
         k = 0;
         while (k < 32 && top[k]) begin
            k++;
         end
         case (model_cfg[i][pmp_pkg::CFG_A_LO +: 2])
            pmp_pkg::MODE_TOR:   hit = (word >= base) && (word < top);
            pmp_pkg::MODE_NA4:   hit = (word == top);
            pmp_pkg::MODE_NAPOT: hit = ((word >> (k + 1)) == (top >> (k + 1)));
            default:             hit = 1'b0;
         endcase
         if (hit && !found) begin
            found = 1'b1;
            win   = model_cfg[i];
         end
      end
      if (!found) begin
         return user;
      end
      // Permission bit named by the access kind
      case (acc)
         3'b001:  allowed = win[pmp_pkg::CFG_R];
         3'b010:  allowed = win[pmp_pkg::CFG_W];
         3'b100:  allowed = win[pmp_pkg::CFG_X];
         default: allowed = 1'b0;
      endcase
      // Machine mode is held only to locked entries
      if (user) begin
         return !allowed;
      end
      return !allowed && win[pmp_pkg::CFG_L];
   endfunction

   // --------------------------------------------------
   // Drivers
   // --------------------------------------------------

   task automatic apply_reset();
      @(posedge clk);
      #(DRIVE_DELAY);
      rst_n = 1'b0;
      repeat (4) @(posedge clk);
      #(DRIVE_DELAY);
      rst_n = 1'b1;
      for (int i = 0; i < ENTRIES; i++) begin
         model_cfg[i]  = '0;
         model_addr[i] = '0;
      end
   endtask

   // One-cycle strobe that is stored on the edge ending the cycle
   task automatic write_csr(input pmp_pkg::csr_addr_t a, input pmp_pkg::csr_data_t d);
      @(posedge clk);
      #(DRIVE_DELAY);
      csr_wen   = 1'b1;
      csr_waddr = a;
      csr_wdata = d;
      @(posedge clk);
      #(DRIVE_DELAY);
      csr_wen = 1'b0;
      ref_write(a, d);
   endtask

   task automatic verify_csr_read(input pmp_pkg::csr_addr_t a);
      @(posedge clk);
      #(DRIVE_DELAY);
      csr_raddr = a;
      #1;
      check_csr($sformatf("csr_rdata[%03h]", a), predict_read(a), csr_rdata);
      check_hit($sformatf("csr_rhit[%03h]", a), predict_hit(a), csr_rhit);
   endtask

   task automatic probe_access(input pmp_pkg::phys_addr_t pa, input pmp_pkg::access_t acc,
                               input logic user);
      @(posedge clk);
      #(DRIVE_DELAY);
      chk_addr   = pa;
      chk_access = acc;
      chk_user   = user;
      #1;
      check_fault($sformatf("chk_fault %08h acc %03b user %0b", pa, acc, user),
                  predict_fault(pa, acc, user), chk_fault);
   endtask

   // Read, write and fetch at one address
   task automatic probe_all_kinds(input pmp_pkg::phys_addr_t pa, input logic user);
      for (int k = 0; k < 3; k++) begin
         probe_access(pa, pmp_pkg::access_t'(3'b001 << k), user);
      end
   endtask

   task automatic verify_entries();
      for (int g = 0; g < ENTRIES / 4; g++) begin
         verify_csr_read(pmp_pkg::CSR_PMPCFG_BASE + 12'(g));
      end
      for (int i = 0; i < ENTRIES; i++) begin
         verify_csr_read(pmp_pkg::CSR_PMPADDR0_BASE + 12'(i));
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (error_count == errors_before) begin
         $display("test %s: pass", name);
      end else begin
         $display("test %s: fail, %0d errors", name, error_count - errors_before);
      end
   endtask

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------

   task automatic reset_state_test();
      int errors_before;
      errors_before = error_count;
      apply_reset();
      for (int g = 0; g < 16; g++) begin
         verify_csr_read(pmp_pkg::CSR_PMPCFG_BASE + 12'(g));
      end
      for (int i = 0; i < 64; i++) begin
         verify_csr_read(pmp_pkg::CSR_PMPADDR0_BASE + 12'(i));
      end
      // Neighbours outside the PMP block
      verify_csr_read(12'h300);
      verify_csr_read(12'h3f0);
      verify_csr_read(12'h7a0);
      // All entries OFF
      for (int n = 0; n < 4; n++) begin
         probe_access(pmp_pkg::phys_addr_t'($random(seed)), 3'b001, 1'b1);
         probe_access(pmp_pkg::phys_addr_t'($random(seed)), 3'b100, 1'b0);
      end
      report_test("reset state", errors_before);
   endtask

   task automatic warl_test();
      int errors_before;
      errors_before = error_count;
      apply_reset();
      // Lock bits kept clear so later tests can reprogram
      for (int g = 0; g < ENTRIES / 4; g++) begin
         write_csr(pmp_pkg::CSR_PMPCFG_BASE + 12'(g), $random(seed) & 32'h7f7f_7f7f);
      end
      for (int i = 0; i < ENTRIES; i++) begin
         write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'(i), $random(seed));
      end
      // Unimplemented entries keep reading zero
      write_csr(pmp_pkg::CSR_PMPADDR16_BASE + 12'd4, $random(seed));
      write_csr(pmp_pkg::CSR_PMPCFG_BASE + 12'd5, $random(seed) & 32'h7f7f_7f7f);
      verify_entries();
      verify_csr_read(pmp_pkg::CSR_PMPADDR16_BASE + 12'd4);
      verify_csr_read(pmp_pkg::CSR_PMPCFG_BASE + 12'd5);
      report_test("warl", errors_before);
   endtask

   task automatic region_test();
      int                  errors_before;
      pmp_pkg::phys_addr_t edges [13];
      errors_before = error_count;
      apply_reset();
      // Entry 1 is only the TOR base of entry 2
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd1, 32'h0000_0800);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd2, 32'h0000_0c00);
      // NA4 word at 0x4000
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd3, 32'h0000_1000);
      // NAPOT of 256 bytes at 0x8000
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd4, 32'h0000_201f);
      // Entry 2 TOR R-X, entry 3 NA4 RW-, entry 4 NAPOT RWX
      write_csr(pmp_pkg::CSR_PMPCFG_BASE, 32'h130d_0000);
      write_csr(pmp_pkg::CSR_PMPCFG_BASE + 12'd1, 32'h0000_001f);
      edges = '{32'h1ffc, 32'h2000, 32'h2ffc, 32'h2fff, 32'h3000, 32'h3ffc, 32'h4000,
                32'h4003, 32'h4004, 32'h7ffc, 32'h8000, 32'h80ff, 32'h8100};
      foreach (edges[n]) begin
         probe_all_kinds(edges[n], 1'b1);
      end
      for (int n = 0; n < 8; n++) begin
         probe_all_kinds(32'h1000 + (32'($random(seed)) & 32'h7ffc), 1'b1);
      end
      // Unlocked entries never stop machine mode
      probe_all_kinds(32'h2800, 1'b0);
      report_test("regions", errors_before);
   endtask

   task automatic priority_test();
      int errors_before;
      errors_before = error_count;
      apply_reset();
      // Entry 0 spans 0x8000 to 0x80ff and entry 1 spans 0x8000 to 0x8fff
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE, 32'h0000_201f);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd1, 32'h0000_21ff);
      // Narrow read-only entry first
      write_csr(pmp_pkg::CSR_PMPCFG_BASE, 32'h0000_1f19);
      probe_all_kinds(32'h8000, 1'b1);
      probe_all_kinds(32'h80fc, 1'b1);
      probe_all_kinds(32'h8100, 1'b1);
      probe_all_kinds(32'h8ffc, 1'b1);
      probe_all_kinds(32'h9000, 1'b1);
      // Roles swapped
      write_csr(pmp_pkg::CSR_PMPCFG_BASE, 32'h0000_191f);
      probe_all_kinds(32'h8040, 1'b1);
      probe_all_kinds(32'h8100, 1'b1);
      report_test("priority", errors_before);
   endtask

   task automatic lock_test();
      int errors_before;
      errors_before = error_count;
      apply_reset();
      // NA4 at 0x100 and TOR over 0x2000 to 0x2fff
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE, 32'h0000_0040);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd1, 32'h0000_0800);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd2, 32'h0000_0c00);
      // Entry 0 is R only and unlocked and entry 2 is a locked TOR R-X
      write_csr(pmp_pkg::CSR_PMPCFG_BASE, 32'h008d_0011);
      probe_all_kinds(32'h0100, 1'b0);
      probe_all_kinds(32'h2800, 1'b0);
      // Base of the locked TOR entry is frozen while entry 3 stays free
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd1, 32'h0000_0123);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd2, 32'h0000_0456);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE + 12'd3, 32'h0000_0789);
      verify_entries();
      // Same entry 0 now locked
      write_csr(pmp_pkg::CSR_PMPCFG_BASE, 32'h008d_0091);
      probe_all_kinds(32'h0100, 1'b0);
      probe_all_kinds(32'h0100, 1'b1);
      // Only the unlocked bytes take this write
      write_csr(pmp_pkg::CSR_PMPCFG_BASE, 32'h001f_1f1f);
      write_csr(pmp_pkg::CSR_PMPADDR0_BASE, 32'h0000_0999);
      verify_entries();
      probe_all_kinds(32'h0100, 1'b0);
      probe_all_kinds(32'h2800, 1'b0);
      report_test("locks", errors_before);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------

   initial begin
      rst_n      = 1'b0;
      csr_wen    = 1'b0;
      csr_waddr  = '0;
      csr_wdata  = '0;
      csr_raddr  = '0;
      chk_addr   = '0;
      chk_access = '0;
      chk_user   = 1'b0;
      reset_state_test();
      warl_test();
      region_test();
      priority_test();
      lock_test();
      $display("pmp_tb: %0d checks passed, %0d errors", pass_count, error_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// File: files.f
+incdir+include
src/pmp_pkg.sv
src/pmp_csr_regs.sv
src/pmp_region_match.sv
src/pmp_priority_resolve.sv
src/pmp_unit.sv
tb/pmp_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PMP testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
   --top-module pmp_tb -f files.f -o pmp_sim

out=$(./obj_dir/pmp_sim)
echo "$out"

# The testbench prints its verdict on a line of its own
if echo "$out" | grep -qx "TEST OK"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi
